/* Makefile */
# Verilator build for the ingress testbench
# Override any variable on the command line, e.g. make run BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= ing_tb
FLIST     ?= ing.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run check clean

all: check

compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status

check: run
	@grep -q "^$(PASS_MSG)$$" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* ing.f */
source/ing_cfg_pkg.sv
source/ing_types_pkg.sv
source/ing_axis_if.sv
source/ing_port_adapt.sv
source/ing_pkt_fifo.sv
source/ing_rr_mux.sv
source/p4_router_ingress.sv
verif/ing_tb_assert.sv
verif/ing_tb.sv

/* source/ing_axis_if.sv */
//////////////////////////////
// No clock inside, users clock it
//////////////////////////////
`timescale 1ns/1ps

interface ing_axis_if;

    import ing_types_pkg::*;

    bus_word_t word;
    logic      valid;
    logic      ready;

    modport src (
        output word,
        output valid,
        input  ready
    );

    modport snk (
        input  word,
        input  valid,
        output ready
    );

endinterface

/* source/ing_cfg_pkg.sv */
//////////////////////////////
// FIFO_DEPTH must be a power of two
// MAX_PKT_WORDS bounds every accepted packet
//////////////////////////////
package ing_cfg_pkg;

    localparam int NUM_PORTS     = 3;
    localparam int IN_BYTES      = 4;
    localparam int BUS_BYTES     = 8;
    localparam int FIFO_DEPTH    = 32;
    localparam int MAX_PKT_WORDS = 8;
    localparam int CNT_WIDTH     = 16;
    localparam int PORT_W        = 2;

    // Derived FIFO widths, free count must reach FIFO_DEPTH itself
    localparam int PTR_W  = $clog2(FIFO_DEPTH);
    localparam int FREE_W = $clog2(FIFO_DEPTH + 1);

endpackage

/* source/ing_pkt_fifo.sv */
//////////////////////////////
// Show-ahead output, a write shows one cycle later
//////////////////////////////
`timescale 1ns/1ps

module ing_pkt_fifo (
    input  logic                           ing_bus,
    input  logic                           rst_n,
    ing_axis_if.snk                        wr,
    ing_axis_if.src                        rd,
    output logic [ing_cfg_pkg::FREE_W-1:0] free_words
);

    import ing_cfg_pkg::*;
    import ing_types_pkg::*;

    bus_word_t         mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [FREE_W-1:0] count;
    logic              do_wr;
    logic              do_rd;

    assign wr.ready   = (count != FREE_W'(FIFO_DEPTH));
    assign do_wr      = wr.valid && wr.ready;
    assign rd.valid   = (count != '0);
    assign do_rd      = rd.valid && rd.ready;
    assign rd.word    = mem[rd_ptr];
    assign free_words = FREE_W'(FIFO_DEPTH) - count;

    always_ff @(posedge ing_bus) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr.word;
        end
    end

    // Pointers wrap on their own width
    always_ff @(posedge ing_bus or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* source/ing_port_adapt.sv */
//////////////////////////////
// Input cannot stall, so a packet is written whole or not at all
// Packets longer than MAX_PKT_WORDS words can overflow the FIFO
//////////////////////////////
`timescale 1ns/1ps

module ing_port_adapt (
    input  logic                                ing_bus,
    input  logic                                rst_n,
    input  logic [ing_cfg_pkg::IN_BYTES*8-1:0]  in_tdata,
    input  logic [ing_cfg_pkg::IN_BYTES-1:0]    in_tkeep,
    input  logic                                in_tlast,
    input  logic                                in_tvalid,
    input  logic                                port_enable,
    input  logic                                cnt_clear,
    input  logic [ing_cfg_pkg::FREE_W-1:0]      free_words,
    ing_axis_if.src                             out,
    output logic [ing_cfg_pkg::CNT_WIDTH-1:0]   pkt_cnt,
    output logic [ing_cfg_pkg::CNT_WIDTH-1:0]   drop_cnt,
    output logic                                buf_full_drop
);

    import ing_cfg_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_ACCEPT,
        S_DISCARD
    } state_t;

    state_t                state;
    logic                  first_beat;
    logic                  room_ok;
    logic                  accept_beat;
    logic                  drop_start;
    logic                  half_valid;
    logic [IN_BYTES*8-1:0] low_data;
    logic [IN_BYTES-1:0]   low_keep;

    //////////////////////////////
    // Packet decision
    //////////////////////////////

    assign first_beat = in_tvalid && (state == S_IDLE);

    // A word written this cycle is not yet in free_words
    assign room_ok = free_words >= FREE_W'(MAX_PKT_WORDS) + FREE_W'(out.valid);

    assign accept_beat = first_beat ? (port_enable && room_ok)
                                    : (in_tvalid && (state == S_ACCEPT));
    assign drop_start  = first_beat && port_enable && !room_ok;

    always_ff @(posedge ing_bus or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else if (in_tvalid) begin
            if (in_tlast) begin
                state <= S_IDLE;
            end else if (first_beat) begin
                state <= accept_beat ? S_ACCEPT : S_DISCARD;
            end
        end
    end

    //////////////////////////////
    // Beat packing
    //////////////////////////////

    always_ff @(posedge ing_bus or negedge rst_n) begin
        if (!rst_n) begin
            half_valid <= 1'b0;
            out.valid  <= 1'b0;
        end else begin
            // Word goes out on the upper beat or on a lone last beat
            out.valid <= accept_beat && (half_valid || in_tlast);
            if (accept_beat) begin
                half_valid <= !half_valid && !in_tlast;
            end
        end
    end

    always_ff @(posedge ing_bus) begin
        if (accept_beat) begin
            if (half_valid) begin
                out.word.data <= {in_tdata, low_data};
                out.word.keep <= {in_tkeep, low_keep};
            end else begin
                low_data      <= in_tdata;
                low_keep      <= in_tkeep;
                // Odd packet end, upper half empty
                out.word.data <= {{(IN_BYTES*8){1'b0}}, in_tdata};
                out.word.keep <= {{IN_BYTES{1'b0}}, in_tkeep};
            end
            out.word.last <= in_tlast;
        end
    end

    //////////////////////////////
    // Counters
    //////////////////////////////

    always_ff @(posedge ing_bus or negedge rst_n) begin
        if (!rst_n) begin
            pkt_cnt       <= '0;
            drop_cnt      <= '0;
            buf_full_drop <= 1'b0;
        end else begin
            buf_full_drop <= drop_start;
            if (cnt_clear) begin
                pkt_cnt  <= '0;
                drop_cnt <= '0;
            end else begin
                if (accept_beat && in_tlast) begin
                    pkt_cnt <= pkt_cnt + 1'b1;
                end
                if (drop_start) begin
                    drop_cnt <= drop_cnt + 1'b1;
                end
            end
        end
    end

endmodule

/* source/ing_rr_mux.sv */
//////////////////////////////
// Packet-level arbitration, a grant holds until last
//////////////////////////////
`timescale 1ns/1ps

module ing_rr_mux (
    input  logic                     ing_bus,
    input  logic                     rst_n,
    ing_axis_if.snk                  in [ing_cfg_pkg::NUM_PORTS],
    output ing_types_pkg::bus_word_t out_word,
    output ing_types_pkg::port_idx_t out_port,
    output logic                     out_valid,
    input  logic                     out_ready
);

    import ing_cfg_pkg::*;
    import ing_types_pkg::*;

    logic [NUM_PORTS-1:0] in_valid;
    logic [NUM_PORTS-1:0] in_ready;
    bus_word_t            in_word [NUM_PORTS];
    port_idx_t            rr_ptr;
    port_idx_t            sel;
    port_idx_t            grant_idx;
    port_idx_t            cur_port;
    logic                 locked;
    logic                 any_valid;
    logic                 cur_ok;
    logic                 load;
    logic                 take;

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_in
        assign in_valid[i] = in[i].valid;
        assign in_word[i]  = in[i].word;
        assign in_ready[i] = take && (cur_port == port_idx_t'(i));
        assign in[i].ready = in_ready[i];
    end

    //////////////////////////////
    // Arbitration
    //////////////////////////////

    // First valid port at or after rr_ptr, lowest offset wins
    always_comb begin
        int idx;
        grant_idx = rr_ptr;
        any_valid = 1'b0;
        for (int k = NUM_PORTS - 1; k >= 0; k--) begin
            idx = (int'(rr_ptr) + k) % NUM_PORTS;
            if (in_valid[idx]) begin
                grant_idx = port_idx_t'(idx);
                any_valid = 1'b1;
            end
        end
    end

    assign cur_port = locked ? sel : grant_idx;
    assign cur_ok   = locked ? in_valid[cur_port] : any_valid;

    // Output register is free when empty or draining
    assign load = !out_valid || out_ready;
    assign take = load && cur_ok;

    always_ff @(posedge ing_bus or negedge rst_n) begin
        if (!rst_n) begin
            locked    <= 1'b0;
            sel       <= '0;
            rr_ptr    <= '0;
            out_valid <= 1'b0;
        end else begin
            if (load) begin
                out_valid <= take;
            end
            if (take) begin
                locked <= !in_word[cur_port].last;
                sel    <= cur_port;
                if (!locked) begin
                    rr_ptr <= (grant_idx == port_idx_t'(NUM_PORTS - 1)) ? '0
                                                                        : grant_idx + 1'b1;
                end
            end
        end
    end

    //////////////////////////////
    // Output register
    //////////////////////////////

    always_ff @(posedge ing_bus) begin
        if (take) begin
            out_word <= in_word[cur_port];
            out_port <= cur_port;
        end
    end

endmodule

/* source/ing_types_pkg.sv */
//////////////////////////////
// Bus word is exactly two input beats wide
//////////////////////////////
package ing_types_pkg;

    // One word of the internal bus
    typedef struct packed {
        logic [ing_cfg_pkg::BUS_BYTES*8-1:0] data;
        logic [ing_cfg_pkg::BUS_BYTES-1:0]   keep;
        logic                                last;
    } bus_word_t;

    // Source port number carried in tuser
    typedef logic [ing_cfg_pkg::PORT_W-1:0] port_idx_t;

endpackage

/* source/p4_router_ingress.sv */
//////////////////////////////
// All ports share ing_bus; inputs are never back-pressured
// Per-port buses are packed, port 0 in the low bits
//////////////////////////////
`timescale 1ns/1ps

module p4_router_ingress (
    input  logic                                                         ing_bus,
    input  logic                                                         rst_n,
    input  logic [ing_cfg_pkg::NUM_PORTS*ing_cfg_pkg::IN_BYTES*8-1:0]    in_tdata,
    input  logic [ing_cfg_pkg::NUM_PORTS*ing_cfg_pkg::IN_BYTES-1:0]      in_tkeep,
    input  logic [ing_cfg_pkg::NUM_PORTS-1:0]                            in_tlast,
    input  logic [ing_cfg_pkg::NUM_PORTS-1:0]                            in_tvalid,
    input  logic [ing_cfg_pkg::NUM_PORTS-1:0]                            port_enable,
    input  logic [ing_cfg_pkg::NUM_PORTS-1:0]                            cnt_clear,
    output logic [ing_cfg_pkg::BUS_BYTES*8-1:0]                          ing_tdata,
    output logic [ing_cfg_pkg::BUS_BYTES-1:0]                            ing_tkeep,
    output logic                                                         ing_tlast,
    output logic [ing_cfg_pkg::PORT_W-1:0]                               ing_tuser,
    output logic                                                         ing_tvalid,
    input  logic                                                         ing_tready,
    output logic [ing_cfg_pkg::NUM_PORTS*ing_cfg_pkg::CNT_WIDTH-1:0]     pkt_cnt,
    output logic [ing_cfg_pkg::NUM_PORTS*ing_cfg_pkg::CNT_WIDTH-1:0]     drop_cnt,
    output logic [ing_cfg_pkg::NUM_PORTS-1:0]                            buf_full_drop
);

    import ing_cfg_pkg::*;
    import ing_types_pkg::*;

    ing_axis_if        adapt_if [NUM_PORTS] ();
    ing_axis_if        fifo_if  [NUM_PORTS] ();
    logic [FREE_W-1:0] free_words [NUM_PORTS];
    bus_word_t         out_word;

    // Adapter and FIFO per ingress port
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        ing_port_adapt adapt_i (
            .ing_bus       (ing_bus),
            .rst_n         (rst_n),
            .in_tdata      (in_tdata[p*IN_BYTES*8 +: IN_BYTES*8]),
            .in_tkeep      (in_tkeep[p*IN_BYTES +: IN_BYTES]),
            .in_tlast      (in_tlast[p]),
            .in_tvalid     (in_tvalid[p]),
            .port_enable   (port_enable[p]),
            .cnt_clear     (cnt_clear[p]),
            .free_words    (free_words[p]),
            .out           (adapt_if[p]),
            .pkt_cnt       (pkt_cnt[p*CNT_WIDTH +: CNT_WIDTH]),
            .drop_cnt      (drop_cnt[p*CNT_WIDTH +: CNT_WIDTH]),
            .buf_full_drop (buf_full_drop[p])
        );

        ing_pkt_fifo fifo_i (
            .ing_bus    (ing_bus),
            .rst_n      (rst_n),
            .wr         (adapt_if[p]),
            .rd         (fifo_if[p]),
            .free_words (free_words[p])
        );
    end

    ing_rr_mux mux_i (
        .ing_bus   (ing_bus),
        .rst_n     (rst_n),
        .in        (fifo_if),
        .out_word  (out_word),
        .out_port  (ing_tuser),
        .out_valid (ing_tvalid),
        .out_ready (ing_tready)
    );

    assign ing_tdata = out_word.data;
    assign ing_tkeep = out_word.keep;
    assign ing_tlast = out_word.last;

endmodule

/* verif/ing_tb.sv */
//////////////////////////////
// One packet at a time, in table order
// Watchdog limit follows the table lengths
//////////////////////////////
`timescale 1ns/1ps

module ing_tb;

    import ing_cfg_pkg::*;
    import ing_types_pkg::*;

    typedef struct packed {
        logic [2:0] tst;
        logic [1:0] port;
        logic [4:0] beats;
        logic [3:0] lkeep;
        logic       en;
        logic [1:0] rmode;
        logic [1:0] outcome;
    } stim_t;

    localparam logic [1:0] R_HIGH   = 2'd0;
    localparam logic [1:0] R_LOW    = 2'd1;
    localparam logic [1:0] R_RAND   = 2'd2;
    localparam logic [1:0] OUT_ACC  = 2'd0;
    localparam logic [1:0] OUT_DIS  = 2'd1;
    localparam logic [1:0] OUT_DROP = 2'd2;
    localparam logic [31:0] SEED    = 32'h8303_48bd;
    localparam int N_STIM    = 27;
    localparam int RR_TEST   = 5;
    localparam int WD_MARGIN = 400;
    localparam int RR_ORDER [4] = '{0, 1, 2, 0};

    // Test, port, beats, last keep, enable, ready mode and outcome per entry
    localparam stim_t STIM [N_STIM] = '{
        '{3'd1, 2'd0, 5'd1,  4'h1, 1'b1, R_HIGH, OUT_ACC},
        '{3'd1, 2'd0, 5'd2,  4'h3, 1'b1, R_HIGH, OUT_ACC},
        '{3'd1, 2'd0, 5'd5,  4'h7, 1'b1, R_HIGH, OUT_ACC},
        '{3'd1, 2'd0, 5'd4,  4'hf, 1'b1, R_HIGH, OUT_ACC},
        '{3'd1, 2'd1, 5'd3,  4'h1, 1'b1, R_HIGH, OUT_ACC},
        '{3'd2, 2'd1, 5'd6,  4'h7, 1'b1, R_HIGH, OUT_ACC},
        '{3'd2, 2'd2, 5'd3,  4'hf, 1'b1, R_HIGH, OUT_ACC},
        '{3'd2, 2'd0, 5'd7,  4'h1, 1'b1, R_HIGH, OUT_ACC},
        '{3'd2, 2'd2, 5'd4,  4'h3, 1'b1, R_HIGH, OUT_ACC},
        '{3'd3, 2'd1, 5'd4,  4'hf, 1'b0, R_HIGH, OUT_DIS},
        '{3'd3, 2'd2, 5'd5,  4'h3, 1'b1, R_HIGH, OUT_ACC},
        '{3'd3, 2'd1, 5'd3,  4'h7, 1'b1, R_HIGH, OUT_ACC},
        '{3'd4, 2'd0, 5'd16, 4'hf, 1'b1, R_LOW,  OUT_ACC},
        '{3'd4, 2'd0, 5'd16, 4'hf, 1'b1, R_LOW,  OUT_ACC},
        '{3'd4, 2'd0, 5'd16, 4'hf, 1'b1, R_LOW,  OUT_ACC},
        '{3'd4, 2'd0, 5'd16, 4'hf, 1'b1, R_LOW,  OUT_ACC},
        '{3'd4, 2'd0, 5'd16, 4'hf, 1'b1, R_LOW,  OUT_DROP},
        '{3'd5, 2'd0, 5'd4,  4'hf, 1'b1, R_LOW,  OUT_ACC},
        '{3'd5, 2'd0, 5'd3,  4'h3, 1'b1, R_LOW,  OUT_ACC},
        '{3'd5, 2'd1, 5'd2,  4'h1, 1'b1, R_LOW,  OUT_ACC},
        '{3'd5, 2'd2, 5'd5,  4'hf, 1'b1, R_LOW,  OUT_ACC},
        '{3'd6, 2'd2, 5'd7,  4'h7, 1'b1, R_RAND, OUT_ACC},
        '{3'd6, 2'd0, 5'd3,  4'hf, 1'b1, R_RAND, OUT_ACC},
        '{3'd6, 2'd1, 5'd6,  4'h3, 1'b1, R_RAND, OUT_ACC},
        '{3'd6, 2'd2, 5'd1,  4'h1, 1'b1, R_RAND, OUT_ACC},
        '{3'd6, 2'd0, 5'd8,  4'hf, 1'b1, R_RAND, OUT_ACC},
        '{3'd6, 2'd1, 5'd5,  4'h1, 1'b1, R_RAND, OUT_ACC}
    };

    logic                              ing_bus       = 1'b0;
    logic                              rst_n         = 1'b0;
    logic [NUM_PORTS*IN_BYTES*8-1:0]   in_tdata      = '0;
    logic [NUM_PORTS*IN_BYTES-1:0]     in_tkeep      = '0;
    logic [NUM_PORTS-1:0]              in_tlast      = '0;
    logic [NUM_PORTS-1:0]              in_tvalid     = '0;
    logic [NUM_PORTS-1:0]              port_enable   = '1;
    logic [NUM_PORTS-1:0]              cnt_clear     = '0;
    logic                              ing_tready    = 1'b1;
    logic [BUS_BYTES*8-1:0]            ing_tdata;
    logic [BUS_BYTES-1:0]              ing_tkeep;
    logic                              ing_tlast;
    logic [PORT_W-1:0]                 ing_tuser;
    logic                              ing_tvalid;
    logic [NUM_PORTS*CNT_WIDTH-1:0]    pkt_cnt;
    logic [NUM_PORTS*CNT_WIDTH-1:0]    drop_cnt;
    logic [NUM_PORTS-1:0]              buf_full_drop;

    bus_word_t   exp_q [NUM_PORTS][$];
    int          exp_pkt [NUM_PORTS];
    int          exp_drop [NUM_PORTS];
    int          exp_pulse [NUM_PORTS];
    int          pulse_cnt [NUM_PORTS];
    int          start_ports [$];
    int          errors = 0;
    int          test_start_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    bit          in_pkt = 1'b0;
    int          cur_port = 0;
    logic [1:0]  ready_mode = R_HIGH;
    logic [31:0] data_seed = SEED;
    logic [31:0] ready_seed = SEED;

    p4_router_ingress p4_router_ingress_i (.*);

    bind p4_router_ingress ing_tb_assert assert_i (
        .ing_bus    (ing_bus),
        .rst_n      (rst_n),
        .ing_tdata  (ing_tdata),
        .ing_tkeep  (ing_tkeep),
        .ing_tlast  (ing_tlast),
        .ing_tuser  (ing_tuser),
        .ing_tvalid (ing_tvalid),
        .ing_tready (ing_tready)
    );

    initial begin
        forever #5 ing_bus = ~ing_bus;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic string test_name(input int t);
        case (t)
            1:       return "packing";
            2:       return "port index and order";
            3:       return "disable";
            4:       return "buffer-full drop";
            5:       return "round robin";
            6:       return "random back-pressure";
            default: return "counter clear";
        endcase
    endfunction

    task automatic compare_value(input logic [63:0] got, input logic [63:0] want,
                                 input string what);
        if (got !== want) begin
            errors++;
            $display("FAILED at %0d ns: %s, got %0h, expected %0h", $time, what, got, want);
        end
    endtask

    //////////////////////////////
    // Stimulus and reference model
    //////////////////////////////

    task automatic send_packet(input stim_t s);
        logic [31:0] beat_data [32];
        logic [3:0]  beat_keep [32];
        bus_word_t   w;
        int          p;
        int          n;
        p = int'(s.port);
        n = int'(s.beats);
        for (int b = 0; b < n; b++) begin
            data_seed    = lcg_next(data_seed);
            beat_data[b] = data_seed;
            beat_keep[b] = (b == n - 1) ? s.lkeep : 4'hf;
        end
        if (s.outcome == OUT_ACC) begin
            // First beat of each pair in the low half
            for (int b = 0; b < n; b += 2) begin
                w.data = {32'h0, beat_data[b]};
                w.keep = {4'h0, beat_keep[b]};
                if (b + 1 < n) begin
                    w.data[63:32] = beat_data[b+1];
                    w.keep[7:4]   = beat_keep[b+1];
                end
                w.last = (b + 2 >= n);
                exp_q[p].push_back(w);
            end
            exp_pkt[p]++;
        end else if (s.outcome == OUT_DROP) begin
            exp_drop[p]++;
            exp_pulse[p]++;
        end
        ready_mode <= s.rmode;
        for (int b = 0; b < n; b++) begin
            @(posedge ing_bus);
            in_tvalid[p]                 <= 1'b1;
            in_tdata[p*IN_BYTES*8 +: 32] <= beat_data[b];
            in_tkeep[p*IN_BYTES +: 4]    <= beat_keep[b];
            in_tlast[p]                  <= (b == n - 1);
            port_enable[p]               <= s.en;
        end
        @(posedge ing_bus);
        in_tvalid[p]   <= 1'b0;
        in_tlast[p]    <= 1'b0;
        port_enable[p] <= 1'b1;
    endtask

    task automatic check_counters();
        for (int p = 0; p < NUM_PORTS; p++) begin
            compare_value(64'(pkt_cnt[p*CNT_WIDTH +: CNT_WIDTH]), 64'(exp_pkt[p]),
                          $sformatf("port %0d pkt_cnt", p));
            compare_value(64'(drop_cnt[p*CNT_WIDTH +: CNT_WIDTH]), 64'(exp_drop[p]),
                          $sformatf("port %0d drop_cnt", p));
            compare_value(64'(pulse_cnt[p]), 64'(exp_pulse[p]),
                          $sformatf("port %0d buf_full_drop pulses", p));
        end
    endtask

    task automatic report_test(input int tst);
        tests_run++;
        if (errors != test_start_errors) begin
            tests_failed++;
        end
        $display("Test %0d (%s) finished with %0d errors", tst, test_name(tst),
                 errors - test_start_errors);
    endtask

    // Release the output, wait for the expected words, then check
    task automatic finish_test(input int tst);
        ready_mode <= R_HIGH;
        while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() != 0) begin
            @(posedge ing_bus);
        end
        repeat (4) @(posedge ing_bus);
        check_counters();
        if (in_pkt) begin
            errors++;
            $display("Output packet from port %0d never ended", cur_port);
        end
        if (tst == RR_TEST) begin
            if (start_ports.size() != 4) begin
                errors++;
                $display("Round robin test saw %0d packets instead of 4", start_ports.size());
            end else begin
                for (int k = 0; k < 4; k++) begin
                    compare_value(64'(start_ports[k]), 64'(RR_ORDER[k]),
                                  $sformatf("round robin packet %0d port", k));
                end
            end
        end
        report_test(tst);
    endtask

    //////////////////////////////
    // Output side
    //////////////////////////////

    always @(posedge ing_bus) begin
        if (ready_mode == R_RAND) begin
            ready_seed = lcg_next(ready_seed);
            ing_tready <= ready_seed[16];
        end else begin
            ing_tready <= (ready_mode == R_HIGH);
        end
    end

    always @(posedge ing_bus) begin : monitor
        bus_word_t exp_w;
        int        p;
        if (rst_n && ing_tvalid && ing_tready) begin
            p = int'(ing_tuser);
            if (p >= NUM_PORTS) begin
                errors++;
                $display("Output word carries invalid port %0d", p);
            end else if (exp_q[p].size() == 0) begin
                errors++;
                $display("Unexpected output word from port %0d at %0d ns", p, $time);
            end else begin
                exp_w = exp_q[p].pop_front();
                compare_value(ing_tdata, exp_w.data, $sformatf("port %0d data", p));
                compare_value(64'(ing_tkeep), 64'(exp_w.keep), $sformatf("port %0d keep", p));
                compare_value(64'(ing_tlast), 64'(exp_w.last), $sformatf("port %0d last", p));
                if (in_pkt) begin
                    compare_value(64'(p), 64'(cur_port), "tuser inside a packet");
                end else begin
                    start_ports.push_back(p);
                end
                in_pkt   = !ing_tlast;
                cur_port = p;
            end
        end
    end

    always @(posedge ing_bus) begin
        if (rst_n) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (buf_full_drop[p]) begin
                    pulse_cnt[p]++;
                end
            end
        end
    end

    //////////////////////////////
    // Sequence and watchdog
    //////////////////////////////

    initial begin
        int cur_tst;
        cur_tst = 0;
        repeat (2) @(posedge ing_bus);
        rst_n <= 1'b1;
        for (int i = 0; i < N_STIM; i++) begin
            if (int'(STIM[i].tst) != cur_tst) begin
                cur_tst           = int'(STIM[i].tst);
                test_start_errors = errors;
                start_ports.delete();
            end
            send_packet(STIM[i]);
            if (i == N_STIM - 1 || STIM[i+1].tst != STIM[i].tst) begin
                finish_test(cur_tst);
            end
        end
        // Both counters of every port back to zero
        test_start_errors = errors;
        cnt_clear <= '1;
        @(posedge ing_bus);
        cnt_clear <= '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            exp_pkt[p]  = 0;
            exp_drop[p] = 0;
        end
        repeat (2) @(posedge ing_bus);
        check_counters();
        report_test(7);
        if (p4_router_ingress_i.assert_i.fail_count != 0) begin
            errors += p4_router_ingress_i.assert_i.fail_count;
            $display("Output stream assertions failed %0d times",
                     p4_router_ingress_i.assert_i.fail_count);
        end
        $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        int limit;
        limit = WD_MARGIN;
        for (int i = 0; i < N_STIM; i++) begin
            limit += 4 * int'(STIM[i].beats);
        end
        repeat (limit) @(posedge ing_bus);
        $display("Timeout after %0d cycles, the output stream never drained", limit);
        $display("Errors found");
        $finish;
    end

endmodule

/* verif/ing_tb_assert.sv */
//////////////////////////////
// Watches only the top-level output stream
//////////////////////////////
`timescale 1ns/1ps

module ing_tb_assert (
    input logic                             ing_bus,
    input logic                             rst_n,
    input logic [ing_cfg_pkg::BUS_BYTES*8-1:0] ing_tdata,
    input logic [ing_cfg_pkg::BUS_BYTES-1:0]   ing_tkeep,
    input logic                             ing_tlast,
    input logic [ing_cfg_pkg::PORT_W-1:0]   ing_tuser,
    input logic                             ing_tvalid,
    input logic                             ing_tready
);

    import ing_cfg_pkg::*;

    // Failed checks so far, the testbench adds them to its total
    int fail_count = 0;

    // Stalled word must wait for its transfer
    valid_hold: assert property (@(posedge ing_bus) disable iff (!rst_n)
        ing_tvalid && !ing_tready |=> ing_tvalid)
        else begin
            fail_count++;
            $error("ing_tvalid dropped while stalled");
        end

    payload_stable: assert property (@(posedge ing_bus) disable iff (!rst_n)
        ing_tvalid && !ing_tready |=> $stable({ing_tdata, ing_tkeep, ing_tlast, ing_tuser}))
        else begin
            fail_count++;
            $error("Output payload changed while stalled");
        end

    tuser_range: assert property (@(posedge ing_bus) disable iff (!rst_n)
        ing_tvalid |-> int'(ing_tuser) < NUM_PORTS)
        else begin
            fail_count++;
            $error("ing_tuser out of range");
        end

    reset_quiet: assert property (@(posedge ing_bus)
        !rst_n |-> !ing_tvalid)
        else begin
            fail_count++;
            $error("ing_tvalid high in reset");
        end

endmodule
